//--- verilog/cast_fmt_pkg.sv
package cast_fmt_pkg;

  // ----------------------------------------
  // binary32 layout
  // ----------------------------------------
  localparam int unsigned FP_WIDTH = 32;  // Full word
  localparam int unsigned EXP_BITS = 8;   // Exponent field
  localparam int unsigned MAN_BITS = 23;  // Stored fraction, no hidden bit
  localparam int unsigned BIAS     = 127; // Exponent bias

  // ----------------------------------------
  // Integer layout
  // ----------------------------------------
  localparam int unsigned INT_WIDTH = 32; // Signed or unsigned word

  // One operand word, read as a float or as a raw integer
  typedef union packed {
    struct packed {
      logic                sign;     // Sign bit
      logic [EXP_BITS-1:0] exponent; // Biased exponent
      logic [MAN_BITS-1:0] mantissa; // Fraction field
    } fp;
    logic [INT_WIDTH-1:0] raw;       // Integer view
  } operand_u;

endpackage

//--- verilog/cast_ctrl_pkg.sv
package cast_ctrl_pkg;

  // ----------------------------------------
  // Operation codes
  // ----------------------------------------
  localparam logic OP_I2F = 1'b0; // Integer to float
  localparam logic OP_F2I = 1'b1; // Float to integer

  // Rounding modes, RISC-V frm order
  localparam logic [2:0] RNE = 3'b000; // Nearest, ties to even
  localparam logic [2:0] RTZ = 3'b001; // Toward zero
  localparam logic [2:0] RDN = 3'b010; // Toward minus infinity
  localparam logic [2:0] RUP = 3'b011; // Toward plus infinity
  localparam logic [2:0] RMM = 3'b100; // Nearest, ties away

  // Flag vector
  localparam int unsigned NUM_FLAGS = 2;
  localparam int unsigned FLAG_NV   = 1; // Invalid
  localparam int unsigned FLAG_NX   = 0; // Inexact

  // ----------------------------------------
  // Internal datapath widths
  // ----------------------------------------
  // Hidden bit plus fraction, or a whole integer, whichever is wider
  localparam int unsigned MANT_W  = 32;
  localparam int unsigned EXP_W   = 10; // Signed, covers -149 .. 128
  localparam int unsigned SHAMT_W = 5;  // Leading-zero count

endpackage

//--- verilog/cast_unpack.sv
`timescale 1ns/1ps

module cast_unpack
  import cast_fmt_pkg::*, cast_ctrl_pkg::*;
(
  input  operand_u                operand_i,
  input  logic                    op_i,
  input  logic                    op_mod_i,    // Unsigned integer source
  output logic                    sign_o,
  output logic signed [EXP_W-1:0] exp_o,       // Unbiased exponent
  output logic [MANT_W-1:0]       mant_o,      // Normalized, MSB is the leading one
  output logic                    mant_zero_o,
  output logic                    is_nan_o,    // Quiet NaN
  output logic                    is_snan_o,   // Signalling NaN
  output logic                    is_inf_o
);

  logic                    exp_all_ones;
  logic                    exp_zero;
  logic                    frac_zero;
  logic                    is_sub;
  logic                    int_sign;
  logic [MANT_W-1:0]       int_mag;
  logic [MANT_W-1:0]       fp_mant;
  logic [MANT_W-1:0]       enc_mant;
  logic [SHAMT_W-1:0]      lz_cnt;
  logic signed [EXP_W-1:0] fp_exp;
  logic signed [EXP_W-1:0] int_exp;

  // ----------------------------------------
  // Float classification
  // ----------------------------------------
  assign exp_all_ones = &operand_i.fp.exponent;
  assign exp_zero     = ~|operand_i.fp.exponent;
  assign frac_zero    = ~|operand_i.fp.mantissa;
  assign is_sub       = exp_zero & ~frac_zero;

  // Fraction MSB separates quiet from signalling
  assign is_nan_o  = exp_all_ones & ~frac_zero & operand_i.fp.mantissa[MAN_BITS-1];
  assign is_snan_o = exp_all_ones & ~frac_zero & ~operand_i.fp.mantissa[MAN_BITS-1];
  assign is_inf_o  = exp_all_ones & frac_zero;

  // Hidden bit only for nonzero exponents, left aligned
  assign fp_mant = {~exp_zero, operand_i.fp.mantissa, {(MANT_W-MAN_BITS-1){1'b0}}};

  // Integer source
  assign int_sign = operand_i.raw[INT_WIDTH-1] & ~op_mod_i; // Unsigned never negative
  assign int_mag  = int_sign ? MANT_W'(-operand_i.raw) : operand_i.raw;

  assign enc_mant = (op_i == OP_I2F) ? int_mag : fp_mant;

  // ----------------------------------------
  // Normalization
  // ----------------------------------------
  // Highest set bit wins
  always_comb begin : lzc
    lz_cnt = '0;
    for (int i = 0; i < MANT_W; i++) begin
      if (enc_mant[i]) lz_cnt = SHAMT_W'(MANT_W - 1 - i);
    end
  end

  assign mant_zero_o = ~|enc_mant;
  assign mant_o      = enc_mant << lz_cnt;

  // Subnormals use exponent 1, then lose one per leading zero
  assign fp_exp  = $signed(EXP_W'(operand_i.fp.exponent)) + $signed(EXP_W'(is_sub))
                 - $signed(EXP_W'(BIAS)) - $signed(EXP_W'(lz_cnt));
  assign int_exp = $signed(EXP_W'(MANT_W - 1)) - $signed(EXP_W'(lz_cnt));

  assign exp_o  = (op_i == OP_I2F) ? int_exp : fp_exp;
  assign sign_o = (op_i == OP_I2F) ? int_sign : operand_i.fp.sign;

endmodule

//--- verilog/cast_align.sv
`timescale 1ns/1ps

module cast_align
  import cast_fmt_pkg::*, cast_ctrl_pkg::*;
(
  input  logic                    op_i,
  input  logic                    op_mod_i,     // Unsigned integer target
  input  logic                    sign_i,
  input  logic signed [EXP_W-1:0] exp_i,
  input  logic [MANT_W-1:0]       mant_i,
  output logic [FP_WIDTH-1:0]     abs_o,        // Magnitude before rounding
  output logic                    round_bit_o,
  output logic                    sticky_o,
  output logic                    over_range_o
);

  logic signed [EXP_W-1:0] i2f_exp;
  logic signed [EXP_W-1:0] shift_dist;
  logic [SHAMT_W:0]        f2i_shamt;  // Up to MANT_W+1
  logic [2*MANT_W:0]       shift_vec;  // Integer, round bit, sticky field
  logic                    min_int;

  // ----------------------------------------
  // I2F packing
  // ----------------------------------------
  assign i2f_exp = exp_i + $signed(EXP_W'(BIAS)); // Always a normal exponent

  // ----------------------------------------
  // F2I shift to integer position
  // ----------------------------------------
  assign shift_dist = $signed(EXP_W'(MANT_W - 1)) - exp_i;

  always_comb begin : f2i_shift
    if (exp_i > $signed(EXP_W'(MANT_W - 1))) begin
      f2i_shamt = '0;                       // Over range, result replaced later
    end else if (exp_i < -1) begin
      f2i_shamt = (SHAMT_W+1)'(MANT_W + 1); // Whole mantissa into sticky
    end else begin
      f2i_shamt = shift_dist[SHAMT_W:0];
    end
  end

  assign shift_vec = {mant_i, {(MANT_W+1){1'b0}}} >> f2i_shamt;

  // Exactly -2^31 still fits a signed target
  assign min_int = ~op_mod_i & sign_i & (exp_i == $signed(EXP_W'(INT_WIDTH - 1)))
                 & (mant_i == {1'b1, {(MANT_W-1){1'b0}}});

  // ----------------------------------------
  // Output select
  // ----------------------------------------
  always_comb begin : sel
    if (op_i == OP_I2F) begin
      // Hidden bit dropped, carry from rounding bumps the exponent
      abs_o        = {1'b0, i2f_exp[EXP_BITS-1:0], mant_i[MANT_W-2 -: MAN_BITS]};
      round_bit_o  = mant_i[MANT_W-2-MAN_BITS];
      sticky_o     = |mant_i[MANT_W-3-MAN_BITS:0];
      over_range_o = 1'b0;
    end else begin
      abs_o        = shift_vec[2*MANT_W -: INT_WIDTH];
      round_bit_o  = shift_vec[MANT_W];
      sticky_o     = |shift_vec[MANT_W-1:0];
      // Unsigned range is one binade wider
      over_range_o = (exp_i >= $signed(EXP_W'(INT_WIDTH - 1 + op_mod_i))) & ~min_int;
    end
  end

endmodule

//--- verilog/cast_finish.sv
`timescale 1ns/1ps

module cast_finish
  import cast_fmt_pkg::*, cast_ctrl_pkg::*;
(
  input  logic                 op_i,
  input  logic                 op_mod_i,     // Unsigned integer target
  input  logic [2:0]           rnd_mode_i,
  input  logic                 sign_i,
  input  logic                 mant_zero_i,  // Integer source was zero
  input  logic                 is_nan_i,
  input  logic                 is_snan_i,
  input  logic                 is_inf_i,
  input  logic [FP_WIDTH-1:0]  abs_i,
  input  logic                 round_bit_i,
  input  logic                 sticky_i,
  input  logic                 over_range_i,
  output logic [FP_WIDTH-1:0]  result_o,
  output logic [NUM_FLAGS-1:0] flags_o
);

  logic                 round_up;
  logic                 inexact;
  logic [FP_WIDTH-1:0]  rounded_abs;
  logic                 rounded_zero;
  logic [FP_WIDTH-1:0]  i2f_res;
  logic [INT_WIDTH-1:0] f2i_res;
  logic                 any_nan;
  logic                 f2i_special;
  logic [INT_WIDTH-1:0] sat_res;

  // ----------------------------------------
  // Rounding
  // ----------------------------------------
  assign inexact = round_bit_i | sticky_i;

  always_comb begin : rnd
    case (rnd_mode_i)
      RNE:     round_up = round_bit_i & (sticky_i | abs_i[0]); // Ties to even LSB
      RTZ:     round_up = 1'b0;
      RDN:     round_up = inexact & sign_i;
      RUP:     round_up = inexact & ~sign_i;
      RMM:     round_up = round_bit_i;
      default: round_up = 1'b0;                                // Reserved codes truncate
    endcase
  end

  assign rounded_abs  = abs_i + FP_WIDTH'(round_up);
  assign rounded_zero = ~|rounded_abs;

  // Regular results
  assign i2f_res = mant_zero_i ? '0 : {sign_i, rounded_abs[FP_WIDTH-2:0]};
  assign f2i_res = sign_i ? INT_WIDTH'(-rounded_abs) : rounded_abs; // Two's complement

  // ----------------------------------------
  // F2I special cases
  // ----------------------------------------
  assign any_nan = is_nan_i | is_snan_i;

  // Negative into unsigned is only invalid if it survives rounding
  assign f2i_special = any_nan | is_inf_i | over_range_i
                     | (sign_i & op_mod_i & ~rounded_zero);

  always_comb begin : saturate
    sat_res = {op_mod_i, {(INT_WIDTH-1){1'b1}}}; // Positive max for the target
    if (sign_i && !any_nan) begin
      sat_res = ~sat_res;                        // Signed min, or zero if unsigned
    end
  end

  // ----------------------------------------
  // Result and flag select
  // ----------------------------------------
  always_comb begin : sel
    flags_o = '0;
    if (op_i == OP_I2F) begin
      result_o         = i2f_res;
      flags_o[FLAG_NX] = inexact;
    end else if (f2i_special) begin
      result_o         = sat_res;
      flags_o[FLAG_NV] = 1'b1;
    end else begin
      result_o         = f2i_res;
      flags_o[FLAG_NX] = inexact;
    end
  end

endmodule

//--- verilog/cast_out_reg.sv
`timescale 1ns/1ps

module cast_out_reg
  import cast_fmt_pkg::*, cast_ctrl_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic [FP_WIDTH-1:0]  result_i,
  input  logic [NUM_FLAGS-1:0] flags_i,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic [FP_WIDTH-1:0]  result_o,
  output logic [NUM_FLAGS-1:0] flags_o
);

  // Free slot, or the held result leaves this cycle
  assign in_ready_o = ~out_valid_o | out_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_valid_o <= 1'b0;
    end else if (in_ready_o) begin
      out_valid_o <= in_valid_i; // Refill or drain
    end
  end

  // Payload only moves on an accepted input
  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      result_o <= result_i;
      flags_o  <= flags_i;
    end
  end

endmodule

//--- verilog/cast_top.sv
`timescale 1ns/1ps

module cast_top
  import cast_fmt_pkg::*, cast_ctrl_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  operand_u             operand_i,   // Float or integer word
  input  logic                 op_i,
  input  logic                 op_mod_i,    // Unsigned integer side
  input  logic [2:0]           rnd_mode_i,
  output logic [FP_WIDTH-1:0]  result_o,
  output logic [NUM_FLAGS-1:0] flags_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i
);

  // ----------------------------------------
  // Unpack to align
  // ----------------------------------------
  logic                    sign;
  logic signed [EXP_W-1:0] exp_unb;
  logic [MANT_W-1:0]       mant_norm;
  logic                    mant_zero;
  logic                    is_nan;
  logic                    is_snan;
  logic                    is_inf;

  // Align to finish
  logic [FP_WIDTH-1:0]     pre_abs;
  logic                    round_bit;
  logic                    sticky;
  logic                    over_range;

  // Finish to output register
  logic [FP_WIDTH-1:0]     result_d;
  logic [NUM_FLAGS-1:0]    flags_d;

  cast_unpack u_unpack (
    .operand_i   (operand_i),
    .op_i        (op_i),
    .op_mod_i    (op_mod_i),
    .sign_o      (sign),
    .exp_o       (exp_unb),
    .mant_o      (mant_norm),
    .mant_zero_o (mant_zero),
    .is_nan_o    (is_nan),
    .is_snan_o   (is_snan),
    .is_inf_o    (is_inf)
  );

  cast_align u_align (
    .op_i         (op_i),
    .op_mod_i     (op_mod_i),
    .sign_i       (sign),
    .exp_i        (exp_unb),
    .mant_i       (mant_norm),
    .abs_o        (pre_abs),
    .round_bit_o  (round_bit),
    .sticky_o     (sticky),
    .over_range_o (over_range)
  );

  cast_finish u_finish (
    .op_i         (op_i),
    .op_mod_i     (op_mod_i),
    .rnd_mode_i   (rnd_mode_i),
    .sign_i       (sign),
    .mant_zero_i  (mant_zero),
    .is_nan_i     (is_nan),
    .is_snan_i    (is_snan),
    .is_inf_i     (is_inf),
    .abs_i        (pre_abs),
    .round_bit_i  (round_bit),
    .sticky_i     (sticky),
    .over_range_i (over_range),
    .result_o     (result_d),
    .flags_o      (flags_d)
  );

  // Single result stage
  cast_out_reg u_out_reg (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .result_i    (result_d),
    .flags_i     (flags_d),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .result_o    (result_o),
    .flags_o     (flags_o)
  );

endmodule

//--- testbench/cast_sva.sv
`timescale 1ns/1ps

module cast_sva
  import cast_fmt_pkg::*, cast_ctrl_pkg::*;
(
  input logic                 clk_i,
  input logic                 rst_i,
  input logic                 in_valid_i,
  input logic                 in_ready_o,
  input logic [FP_WIDTH-1:0]  result_i,
  input logic [NUM_FLAGS-1:0] flags_i,
  input logic                 out_valid_o,
  input logic                 out_ready_i,
  input logic [FP_WIDTH-1:0]  result_o,
  input logic [NUM_FLAGS-1:0] flags_o
);

  int fail_cnt = 0; // Failed assertion count

  // Register comes out of reset empty
  a_reset_empty: assert property (@(posedge clk_i) rst_i |=> !out_valid_o)
    else begin
      $error("out_valid_o high after reset");
      fail_cnt++;
    end

  // Held result frozen under back-pressure
  a_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(result_o) && $stable(flags_o))
    else begin
      $error("Result changed while stalled");
      fail_cnt++;
    end

  // Accepted input shows up with its payload one edge later
  a_load: assert property (@(posedge clk_i) disable iff (rst_i)
    in_valid_i && in_ready_o |=>
      out_valid_o && result_o == $past(result_i) && flags_o == $past(flags_i))
    else begin
      $error("Accepted input not loaded into the output register");
      fail_cnt++;
    end

endmodule

bind cast_out_reg cast_sva u_sva (.*);

//--- testbench/tb_cast.sv
`timescale 1ns/1ps

module tb_cast
  import cast_fmt_pkg::*, cast_ctrl_pkg::*;
();

  localparam int MAX_VEC = 64;
  localparam int VEC_W   = 80; // op, mod, rnd, operand, result, flags

  logic                 clk;
  logic                 rst;
  logic                 in_valid;
  logic                 in_ready;
  logic [31:0]          operand;
  logic                 op;
  logic                 op_mod;
  logic [2:0]           rnd_mode;
  logic [FP_WIDTH-1:0]  result;
  logic [NUM_FLAGS-1:0] flags;
  logic                 out_valid;
  logic                 out_ready;

  logic [VEC_W-1:0]              vec_mem [0:MAX_VEC-1];
  logic [FP_WIDTH+NUM_FLAGS-1:0] exp_q [$]; // Expected {result, flags}, oldest first
  logic [7:0]                    lfsr;
  logic                          accepted;  // Input taken at the last edge
  int                            num_vec;
  int                            num_rcv;
  int                            err_val;
  int                            err_proto;

  cast_top u_dut (
    .clk_i       (clk),
    .rst_i       (rst),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .operand_i   (operand),
    .op_i        (op),
    .op_mod_i    (op_mod),
    .rnd_mode_i  (rnd_mode),
    .result_o    (result),
    .flags_o     (flags),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready)
  );

  always #2 clk = ~clk; // 4 ns period

  // Fibonacci step, taps 8 6 5 4
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  task automatic step_ready();
    lfsr      = lfsr_step(lfsr);
    out_ready = lfsr[0]; // One bit per cycle
  endtask

  task automatic check_latency();
    assert (!accepted || out_valid) else begin
      err_proto++;
      $display("No result one cycle after an accepted input");
    end
    accepted = 1'b0;
  endtask

  task automatic print_counts();
    $display("Error counts: %0d wrong values, %0d protocol errors, %0d assertion failures",
             err_val, err_proto, u_dut.u_out_reg.u_sva.fail_cnt);
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin : drive
    logic [3:0]          f_op;
    logic [3:0]          f_mod;
    logic [3:0]          f_rnd;
    logic [3:0]          f_flg;
    logic [FP_WIDTH-1:0] f_res;
    clk = 1'b0;
    rst = 1'b1;
    in_valid = 1'b0;
    operand = '0;
    op = OP_I2F;
    op_mod = 1'b0;
    rnd_mode = RNE;
    out_ready = 1'b0;
    lfsr = 8'd89;
    accepted = 1'b0;
    num_vec = 0;
    num_rcv = 0;
    err_val = 0;
    err_proto = 0;
    $readmemh("testbench/cast_golden.hex", vec_mem);
    while (num_vec < MAX_VEC && !$isunknown(vec_mem[num_vec])) num_vec++; // Unread slots stay X
    assert (num_vec > 0) else begin
      err_proto++;
      $display("No vectors read from the golden file");
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    #1;
    assert (!out_valid) else begin
      err_proto++;
      $display("out_valid high after reset");
    end
    for (int i = 0; i < num_vec; i++) begin
      @(negedge clk);
      {f_op, f_mod, f_rnd, operand, f_res, f_flg} = vec_mem[i];
      op       = f_op[0];
      op_mod   = f_mod[0];
      rnd_mode = f_rnd[2:0];
      in_valid = 1'b1;
      step_ready();
      #1;
      check_latency();
      while (!in_ready) begin // Stalled, hold the vector
        @(negedge clk);
        step_ready();
        #1;
      end
      exp_q.push_back({f_res, f_flg[NUM_FLAGS-1:0]});
      accepted = 1'b1; // Taken at the coming edge
    end
    @(negedge clk);
    in_valid  = 1'b0;
    out_ready = 1'b1; // Drain
    #1;
    check_latency();
    wait (num_rcv == num_vec);
    print_counts();
    if (err_val + err_proto + u_dut.u_out_reg.u_sva.fail_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // ----------------------------------------
  // Output check, mid low phase
  // ----------------------------------------
  always @(negedge clk) begin : monitor
    logic [FP_WIDTH+NUM_FLAGS-1:0] exp_e;
    #1;
    if (!rst && out_valid && out_ready) begin // Leaves at the next edge
      assert (exp_q.size() > 0) else begin
        err_proto++;
        $display("Result delivered with no input outstanding");
      end
      if (exp_q.size() > 0) begin
        exp_e = exp_q.pop_front();
        assert (result === exp_e[FP_WIDTH+NUM_FLAGS-1:NUM_FLAGS]) else begin
          err_val++;
          $display("Fail result_o vector %0d: got %h, expected %h",
                   num_rcv, result, exp_e[FP_WIDTH+NUM_FLAGS-1:NUM_FLAGS]);
        end
        assert (flags === exp_e[NUM_FLAGS-1:0]) else begin
          err_val++;
          $display("Fail flags_o vector %0d: got %h, expected %h",
                   num_rcv, flags, exp_e[NUM_FLAGS-1:0]);
        end
        num_rcv++;
      end
    end
  end

  // 40 cycles per vector
  initial begin : watchdog
    @(negedge rst);
    repeat (40 * num_vec + 20) @(posedge clk);
    $display("Timeout with %0d of %0d results received", num_rcv, num_vec);
    print_counts();
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- flist.f
verilog/cast_fmt_pkg.sv
verilog/cast_ctrl_pkg.sv
verilog/cast_unpack.sv
verilog/cast_align.sv
verilog/cast_finish.sv
verilog/cast_out_reg.sv
verilog/cast_top.sv
testbench/cast_sva.sv
testbench/tb_cast.sv

//--- Bender.yml
package:
  name: cast_unit

sources:
  - verilog/cast_fmt_pkg.sv
  - verilog/cast_ctrl_pkg.sv
  - verilog/cast_unpack.sv
  - verilog/cast_align.sv
  - verilog/cast_finish.sv
  - verilog/cast_out_reg.sv
  - verilog/cast_top.sv
  - target: test
    files:
      - testbench/cast_sva.sv
      - testbench/tb_cast.sv

//--- testbench/cast_golden.hex
// Columns: op _ op_mod _ rnd_mode _ operand _ expected result _ expected flags (NV=2, NX=1)
// I2F
0_0_0_00000000_00000000_0 // Signed zero
0_0_0_FFFFFFFF_BF800000_0 // Signed -1
0_1_1_80000000_4F000000_0 // Unsigned 2^31, exact
0_0_0_01000001_4B800000_1 // Tie, even wins
0_0_4_01000001_4B800001_1 // Tie, away wins
0_0_1_01000001_4B800000_1
0_0_2_FEFFFFFF_CB800001_1 // Negative tie toward -inf
0_0_3_FEFFFFFF_CB800000_1
0_1_0_FFFFFFFF_4F800000_1 // Unsigned max carries into exponent
// F2I
1_0_0_40200000_00000002_1 // 2.5 to even
1_0_2_C0200000_FFFFFFFD_1 // -2.5 down
1_0_3_C0200000_FFFFFFFE_1 // -2.5 up
1_0_1_3F800000_00000001_0
1_0_3_00000001_00000001_1 // Smallest subnormal rounds up
1_1_0_3F400000_00000001_1 // 0.75 unsigned
1_1_1_BE800000_00000000_1 // Negative but rounds to zero
1_1_1_BF800000_00000000_2 // Negative into unsigned
1_0_0_7FC00000_7FFFFFFF_2 // NaN saturates positive
1_0_0_FF800000_80000000_2 // -inf
1_0_1_4F000000_7FFFFFFF_2 // 2^31 over signed range
1_0_0_CF000000_80000000_0 // -2^31 still fits
1_1_0_4F800000_FFFFFFFF_2 // 2^32 over unsigned range
